//--- hw/boardState.sv
module boardState import matchPkg::*;
(
	input logic clock,
	input logic resetn,

	input logic placeEnable,
	input cellT placeCell,
	input logic placePlayer,

	output logic [cellCount-1:0] player1Cells,
	output logic [cellCount-1:0] player2Cells
);

	// one occupancy bit per cell and player
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			player1Cells <= '0;
			player2Cells <= '0;
		end
		else if (placeEnable)
		begin
			if (placePlayer)
				player2Cells[placeCell.flat] <= 1'b1;
			else
				player1Cells[placeCell.flat] <= 1'b1;
		end
	end

endmodule

//--- hw/matchFour.sv
module matchFour import matchPkg::*;
(
	input logic clock,
	input logic resetn,

	input logic moveValid,
	input cellT moveCell,
	output logic moveReady,

	output logic pixelValid,
	input logic pixelReady,
	output logic [coordW-1:0] pixelX,
	output logic [coordW-1:0] pixelY,
	output logic [colourW-1:0] pixelColour,

	output logic player2Turn,
	output logic moveRejected,
	output logic [1:0] winner
);

	logic [cellCount-1:0] player1Cells;
	logic [cellCount-1:0] player2Cells;
	logic placeEnable;
	cellT placeCell;
	logic placePlayer;
	logic plotStart;
	cellT plotCell;
	logic plotPlayer;
	logic plotDone;

	turnControl control
	(
		.clock(clock),
		.resetn(resetn),
		.moveValid(moveValid),
		.moveCell(moveCell),
		.moveReady(moveReady),
		.player1Cells(player1Cells),
		.player2Cells(player2Cells),
		.winner(winner),
		.placeEnable(placeEnable),
		.placeCell(placeCell),
		.placePlayer(placePlayer),
		.plotStart(plotStart),
		.plotCell(plotCell),
		.plotPlayer(plotPlayer),
		.plotDone(plotDone),
		.player2Turn(player2Turn),
		.moveRejected(moveRejected)
	);

	boardState board
	(
		.clock(clock),
		.resetn(resetn),
		.placeEnable(placeEnable),
		.placeCell(placeCell),
		.placePlayer(placePlayer),
		.player1Cells(player1Cells),
		.player2Cells(player2Cells)
	);

	winDetect detect
	(
		.clock(clock),
		.resetn(resetn),
		.player1Cells(player1Cells),
		.player2Cells(player2Cells),
		.winner(winner)
	);

	squarePlotter plotter
	(
		.clock(clock),
		.resetn(resetn),
		.plotStart(plotStart),
		.plotCell(plotCell),
		.plotPlayer(plotPlayer),
		.plotDone(plotDone),
		.pixelValid(pixelValid),
		.pixelReady(pixelReady),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.pixelColour(pixelColour)
	);

endmodule

//--- hw/matchPkg.sv
package matchPkg;

	// board geometry
	localparam int boardSide = 4;
	localparam int cellCount = boardSide * boardSide;
	localparam int cellW = 4;

	// pixel space of the display
	localparam int coordW = 7;
	localparam int colourW = 3;
	localparam int squareSide = 4; // pixels per side of one piece
	localparam int squarePitch = 8;
	localparam int boardOrigin = 4; // cell 0 starts here in x and y

	localparam logic [colourW-1:0] player1Colour = 3'b100; // red
	localparam logic [colourW-1:0] player2Colour = 3'b110; // yellow

	// game FSM encoding
	localparam int stateW = 2;
	localparam logic [stateW-1:0] stateAwait1 = 2'd0;
	localparam logic [stateW-1:0] stateAwait2 = 2'd1;
	localparam logic [stateW-1:0] statePlot = 2'd2;
	localparam logic [stateW-1:0] stateOver = 2'd3;

	// a cell number, read as a bit index or as row and column
	typedef union packed {
		logic [cellW-1:0] flat;
		struct packed {
			logic [cellW/2-1:0] row;
			logic [cellW/2-1:0] col;
		} grid;
	} cellT;

endpackage

//--- hw/squarePlotter.sv
module squarePlotter import matchPkg::*;
(
	input logic clock,
	input logic resetn,

	input logic plotStart,
	input cellT plotCell,
	input logic plotPlayer,
	output logic plotDone,

	output logic pixelValid,
	input logic pixelReady,
	output logic [coordW-1:0] pixelX,
	output logic [coordW-1:0] pixelY,
	output logic [colourW-1:0] pixelColour
);

	logic [3:0] pixelCount;
	logic transfer;
	logic [coordW-1:0] originX;
	logic [coordW-1:0] originY;

	assign transfer = pixelValid && pixelReady;
	assign plotDone = transfer && (pixelCount == 4'(squareSide * squareSide - 1));

	// counter moves only on a transfer so a stalled pixel stays put
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			pixelValid <= 1'b0;
			pixelCount <= 4'd0;
		end
		else if (plotStart)
		begin
			pixelValid <= 1'b1;
			pixelCount <= 4'd0;
		end
		else if (transfer)
		begin
			if (plotDone)
				pixelValid <= 1'b0;
			pixelCount <= pixelCount + 4'd1;
		end
	end

	// top left corner of the square and its colour, held for the whole plot
	always_ff @(posedge clock)
	begin
		if (plotStart)
		begin
			originX <= coordW'(boardOrigin + squarePitch * plotCell.grid.col);
			originY <= coordW'(boardOrigin + squarePitch * plotCell.grid.row);
			pixelColour <= plotPlayer ? player2Colour : player1Colour;
		end
	end

	// pixels go out row by row
	assign pixelX = originX + coordW'(pixelCount % squareSide);
	assign pixelY = originY + coordW'(pixelCount / squareSide);

endmodule

//--- hw/turnControl.sv
module turnControl import matchPkg::*;
(
	input logic clock,
	input logic resetn,

	input logic moveValid,
	input cellT moveCell,
	output logic moveReady,

	input logic [cellCount-1:0] player1Cells,
	input logic [cellCount-1:0] player2Cells,
	input logic [1:0] winner,

	output logic placeEnable,
	output cellT placeCell,
	output logic placePlayer,

	output logic plotStart,
	output cellT plotCell,
	output logic plotPlayer,
	input logic plotDone,

	output logic player2Turn,
	output logic moveRejected
);

	logic [stateW-1:0] state;
	logic accept;
	logic occupied;
	logic legal;
	logic mover; // 1 when player 2 made the move in flight
	cellT acceptedCell;

	assign moveReady = (state == stateAwait1) || (state == stateAwait2);
	assign accept = moveValid && moveReady;

	// a cell is free only when neither player holds it
	assign occupied = player1Cells[moveCell.flat] || player2Cells[moveCell.flat];
	assign legal = accept && !occupied;

	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			state <= stateAwait1;
			mover <= 1'b0;
			placeEnable <= 1'b0;
			moveRejected <= 1'b0;
		end
		else
		begin
			placeEnable <= legal; // also starts the plot
			moveRejected <= accept && occupied;
			case (state)
				stateAwait1, stateAwait2:
				begin
					if (legal)
					begin
						state <= statePlot;
						mover <= (state == stateAwait2);
					end
				end
				statePlot:
				begin
					// winner has settled long before the last pixel goes out
					if (plotDone)
					begin
						if (winner != 2'b00)
							state <= stateOver;
						else if (mover)
							state <= stateAwait1;
						else
							state <= stateAwait2;
					end
				end
				default:
				begin
					state <= stateOver; // frozen until reset
				end
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (legal)
			acceptedCell <= moveCell;
	end

	// board write and plot share one pulse and one cell
	assign plotStart = placeEnable;
	assign placeCell = acceptedCell;
	assign plotCell = acceptedCell;
	assign placePlayer = mover;
	assign plotPlayer = mover;

	always_comb
	begin
		case (state)
			stateAwait1: player2Turn = 1'b0;
			stateAwait2: player2Turn = 1'b1;
			default: player2Turn = mover; // mover keeps the turn while drawing
		endcase
	end

endmodule

//--- hw/winDetect.sv
module winDetect import matchPkg::*;
(
	input logic clock,
	input logic resetn,

	input logic [cellCount-1:0] player1Cells,
	input logic [cellCount-1:0] player2Cells,

	output logic [1:0] winner
);

	logic player1Line;
	logic player2Line;

	// true when the map covers any row, column or diagonal
	function automatic logic hasLine(input logic [cellCount-1:0] cells);
		logic [cellCount-1:0] rowMask;
		logic [cellCount-1:0] colMask;
		logic [cellCount-1:0] diagMask;
		logic [cellCount-1:0] antiMask;
		logic found;
		found = 1'b0;
		diagMask = '0;
		antiMask = '0;
		for (int i = 0; i < boardSide; i++)
		begin
			rowMask = '0;
			colMask = '0;
			for (int j = 0; j < boardSide; j++)
			begin
				rowMask[i * boardSide + j] = 1'b1;
				colMask[j * boardSide + i] = 1'b1;
			end
			diagMask[i * (boardSide + 1)] = 1'b1; // 0 5 10 15
			antiMask[(i + 1) * (boardSide - 1)] = 1'b1; // 3 6 9 12
			found = found | ((cells & rowMask) == rowMask);
			found = found | ((cells & colMask) == colMask);
		end
		found = found | ((cells & diagMask) == diagMask);
		found = found | ((cells & antiMask) == antiMask);
		return found;
	endfunction

	assign player1Line = hasLine(player1Cells);
	assign player2Line = hasLine(player2Cells);

	always_ff @(posedge clock)
	begin
		if (!resetn)
			winner <= 2'b00;
		else if (player1Line)
			winner <= 2'b01; // player 1 checked first
		else if (player2Line)
			winner <= 2'b10;
		else
			winner <= 2'b00;
	end

endmodule

//--- project.f
hw/matchPkg.sv
hw/boardState.sv
hw/winDetect.sv
hw/squarePlotter.sv
hw/turnControl.sv
hw/matchFour.sv
test/matchChecker.sv
test/matchFourTb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the four-in-a-row testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module matchFourTb -f project.f -o matchSim \
	&& ./obj_dir/matchSim | tee /dev/stderr | grep "Testbench passed" > /dev/null \
	&& { echo "run.sh: simulation ok"; exit 0; } \
	|| { echo "run.sh: simulation not ok"; exit 1; }

//--- test/matchChecker.sv
module matchChecker import matchPkg::*;
(
	input logic clock,
	input logic resetn,
	input logic moveValid,
	input cellT moveCell,
	input logic moveReady,
	input logic pixelValid,
	input logic pixelReady,
	input logic [coordW-1:0] pixelX,
	input logic [coordW-1:0] pixelY,
	input logic [colourW-1:0] pixelColour,
	input logic player2Turn,
	input logic moveRejected,
	input logic [1:0] winner,
	input int testRow,
	input logic [1:0] expectWinner, // from the stimulus table
	output int mismatchCount,
	output int failureCount
);

	// rows, columns, then the two diagonals
	logic [15:0] lineMasks [10] = '{16'h000f, 16'h00f0, 16'h0f00, 16'hf000, 16'h1111,
		16'h2222, 16'h4444, 16'h8888, 16'h8421, 16'h1248};
	logic [15:0] map1;
	logic [15:0] map2;
	logic modelTurn; // 1 while player 2 is to move
	logic gameOver;
	logic inReset = 1'b0;
	logic rejectPending;
	logic plotting;
	logic plotMover;
	logic stalled;
	logic [coordW-1:0] heldX;
	logic [coordW-1:0] heldY;
	logic [colourW-1:0] heldColour;
	int plotRow;
	int plotCol;
	int pixelIndex;
	int mismatches = 0;
	int failures = 0;

	assign mismatchCount = mismatches;
	assign failureCount = failures;

	function automatic logic hasLine(input logic [15:0] cells);
		logic found;
		found = 1'b0;
		for (int n = 0; n < 10; n++)
			if ((cells & lineMasks[n]) == lineMasks[n])
				found = 1'b1;
		return found;
	endfunction

	function automatic int modelWinner();
		if (hasLine(map1))
			return 1;
		else if (hasLine(map2))
			return 2;
		return 0;
	endfunction

	task automatic checkValue(input string what, input int expected, input int actual);
		if (actual != expected)
		begin
			mismatches++;
			$display("Mismatch row%0d %s: expected %0d, actual %0d", testRow, what, expected, actual);
		end
	endtask

	task automatic reportFailure(input string what);
		failures++;
		$display("Error in row%0d: %s", testRow, what);
	endtask

	task automatic checkPixel();
		int expColour;
		expColour = plotMover ? int'(player2Colour) : int'(player1Colour);
		checkValue($sformatf("pixelX of pixel %0d", pixelIndex),
			boardOrigin + squarePitch * plotCol + pixelIndex % squareSide, int'(pixelX));
		checkValue($sformatf("pixelY of pixel %0d", pixelIndex),
			boardOrigin + squarePitch * plotRow + pixelIndex / squareSide, int'(pixelY));
		checkValue($sformatf("pixelColour of pixel %0d", pixelIndex), expColour, int'(pixelColour));
		pixelIndex++;
		if (pixelIndex == squareSide * squareSide)
		begin
			plotting = 1'b0;
			checkValue("winner after the last pixel", int'(expectWinner), int'(winner));
			if (modelWinner() != int'(expectWinner))
				reportFailure("stimulus table and game model disagree on the winner");
			if (modelWinner() != 0)
				gameOver = 1'b1;
			else
				modelTurn = !modelTurn;
		end
	endtask

	task automatic acceptMove();
		if (map1[moveCell.flat] || map2[moveCell.flat])
			rejectPending = 1'b1; // same player has to try again
		else
		begin
			if (modelTurn)
				map2[moveCell.flat] = 1'b1;
			else
				map1[moveCell.flat] = 1'b1;
			plotting = 1'b1;
			plotMover = modelTurn;
			pixelIndex = 0;
			plotRow = int'(moveCell.flat) / boardSide;
			plotCol = int'(moveCell.flat) % boardSide;
		end
	endtask

	always @(posedge clock)
	begin
		if (!resetn)
		begin
			inReset = 1'b1;
			map1 = '0;
			map2 = '0;
			modelTurn = 1'b0;
			gameOver = 1'b0;
			rejectPending = 1'b0;
			plotting = 1'b0;
			stalled = 1'b0;
		end
		else
		begin
			if (inReset)
			begin
				checkValue("moveReady after reset", 1, int'(moveReady));
				checkValue("pixelValid after reset", 0, int'(pixelValid));
				checkValue("player2Turn after reset", 0, int'(player2Turn));
				checkValue("winner after reset", 0, int'(winner));
			end
			inReset = 1'b0;
			checkValue("moveRejected", int'(rejectPending), int'(moveRejected));
			rejectPending = 1'b0;
			if (moveReady && gameOver)
				reportFailure("moveReady went high after the game was won");
			if (moveReady && plotting)
				reportFailure("moveReady went high before the square was finished");
			if (moveReady && !gameOver)
			begin
				checkValue("player2Turn", int'(modelTurn), int'(player2Turn));
				checkValue("winner", modelWinner(), int'(winner));
			end
			// a stalled pixel has to wait unchanged
			if (stalled && (!pixelValid || pixelX != heldX || pixelY != heldY
				|| pixelColour != heldColour))
				reportFailure("the pixel changed or vanished while pixelReady was low");
			stalled = pixelValid && !pixelReady;
			heldX = pixelX;
			heldY = pixelY;
			heldColour = pixelColour;
			if (pixelValid && pixelReady)
			begin
				if (plotting)
					checkPixel();
				else
					reportFailure("a pixel was sent with no move being drawn");
			end
			if (moveValid && moveReady)
				acceptMove();
		end
	end

endmodule

//--- test/matchFourTb.sv
module matchFourTb import matchPkg::*;
();

	localparam int rowCount = 32;
	localparam int waitLimit = 300; // cycles per row
	localparam int watchdogTime = rowCount * waitLimit * 20;

	// one game per line, player 1 moves first: row, column, diagonal, anti-diagonal
	logic [3:0] cellTable [rowCount] = '{
		4'd0, 4'd4, 4'd4, 4'd1, 4'd5, 4'd2, 4'd6, 4'd3,
		4'd0, 4'd1, 4'd2, 4'd5, 4'd3, 4'd9, 4'd4, 4'd13,
		4'd0, 4'd1, 4'd5, 4'd5, 4'd2, 4'd10, 4'd3, 4'd15,
		4'd0, 4'd3, 4'd1, 4'd6, 4'd4, 4'd9, 4'd8, 4'd12};
	logic resetTable [rowCount] = '{
		0, 0, 0, 0, 0, 0, 0, 0,
		1, 0, 0, 0, 0, 0, 0, 0,
		1, 0, 0, 0, 0, 0, 0, 0,
		1, 0, 0, 0, 0, 0, 0, 0};
	logic [1:0] winnerTable [rowCount] = '{
		0, 0, 0, 0, 0, 0, 0, 1,
		0, 0, 0, 0, 0, 0, 0, 2,
		0, 0, 0, 0, 0, 0, 0, 1,
		0, 0, 0, 0, 0, 0, 0, 2};

	logic clock = 1'b0;
	logic resetn;
	logic moveValid;
	cellT moveCell;
	logic moveReady;
	logic pixelValid;
	logic pixelReady = 1'b0;
	logic [coordW-1:0] pixelX;
	logic [coordW-1:0] pixelY;
	logic [colourW-1:0] pixelColour;
	logic player2Turn;
	logic moveRejected;
	logic [1:0] winner;
	int row = 0;
	int seed = 32'hde41;
	int timeouts = 0;
	int mismatchCount;
	int failureCount;

	always #10 clock = ~clock;

	// random back-pressure on the pixel channel
	always @(negedge clock)
		pixelReady = ($random(seed) & 3) != 0;

	matchFour dut
	(
		.clock(clock), .resetn(resetn), .moveValid(moveValid), .moveCell(moveCell),
		.moveReady(moveReady), .pixelValid(pixelValid), .pixelReady(pixelReady),
		.pixelX(pixelX), .pixelY(pixelY), .pixelColour(pixelColour),
		.player2Turn(player2Turn), .moveRejected(moveRejected), .winner(winner)
	);

	matchChecker gameCheck
	(
		.clock(clock), .resetn(resetn), .moveValid(moveValid), .moveCell(moveCell),
		.moveReady(moveReady), .pixelValid(pixelValid), .pixelReady(pixelReady),
		.pixelX(pixelX), .pixelY(pixelY), .pixelColour(pixelColour),
		.player2Turn(player2Turn), .moveRejected(moveRejected), .winner(winner),
		.testRow(row), .expectWinner(winnerTable[row]),
		.mismatchCount(mismatchCount), .failureCount(failureCount)
	);

	task automatic applyReset();
		resetn = 1'b0;
		repeat (10) @(negedge clock);
		resetn = 1'b1;
	endtask

	task automatic waitReady();
		int count;
		count = 0;
		while (!moveReady && count < waitLimit)
		begin
			@(negedge clock);
			count++;
		end
		if (!moveReady)
		begin
			timeouts++;
			$display("Row %0d: moveReady never came high", row);
		end
	endtask

	// done when the next move can go in, or the winning square is fully drawn
	task automatic waitSettled();
		int count;
		count = 0;
		while (!moveReady && !(winner != 2'b00 && !pixelValid) && count < waitLimit)
		begin
			@(negedge clock);
			count++;
		end
		if (count == waitLimit)
		begin
			timeouts++;
			$display("Row %0d: the move never finished", row);
		end
	endtask

	initial
	begin
		resetn = 1'b0;
		moveValid = 1'b0;
		moveCell = '0;
		@(negedge clock);
		applyReset();
		for (int i = 0; i < rowCount; i++)
		begin
			row = i;
			if (resetTable[i])
				applyReset();
			waitReady();
			moveValid = 1'b1;
			moveCell = cellTable[i];
			@(negedge clock);
			moveValid = 1'b0;
			waitSettled();
			if (winner != 2'b00)
				repeat (4) @(negedge clock); // a won game has to stay frozen
		end
		repeat (3) @(negedge clock);
		$display("Error counts: %0d mismatches, %0d failures, %0d timeouts",
			mismatchCount, failureCount, timeouts);
		if (mismatchCount + failureCount + timeouts == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial
	begin
		#(watchdogTime);
		$display("Watchdog expired in row %0d after %0d time units", row, watchdogTime);
		$display("Testbench failed");
		$finish;
	end

endmodule
